//--- verilog/frame_pkg.sv
package frame_pkg;

  // --------------------
  // link geometry
  // --------------------

  // data lanes per front-end chip
  localparam int MXIO = 8;

  // slip setting width, delays of 1 to 16 cycles
  localparam int SLIP_BITS = 4;

  // --------------------
  // alignment control
  // --------------------

  // consecutive aligned frames before the channel is declared locked
  localparam int MXSTABLE = 16;

  // frames between slip checks
  // a new slip value needs a few frames to reach the sof comparison
  localparam int CHECK_FRAMES = 4;

  // saturating per-channel error counter width
  localparam int ERR_COUNT_BITS = 8;

  // --------------------
  // payload types
  // --------------------

  // both bits of one fastclock cycle for every lane, d0 is the earlier bit
  typedef struct packed {
    logic [MXIO-1:0] d0;
    logic [MXIO-1:0] d1;
  } lane_pair_t;

endpackage

//--- verilog/sbit_link_if.sv
`timescale 1ns/1ps

interface sbit_link_if import frame_pkg::*; #(
  parameter int WORD_SIZE = 8
);

  // one aligned word per frame, lane i at bits i*WORD_SIZE and up
  logic [MXIO*WORD_SIZE-1:0] sbits;

  // delayed start of frame, lined up with the deserialized word
  logic sof_delayed;

  // channel locked to the frame strobe
  logic ready;

  // frame missed its sof edge while locked, held for one frame
  logic alignment_error;

  // aligner side
  modport source (output sbits, sof_delayed, ready, alignment_error);

  // collector side
  modport sink (input sbits, sof_delayed, ready, alignment_error);

endinterface

//--- verilog/delay_line.sv
`timescale 1ns/1ps

module delay_line import frame_pkg::*; #(
  parameter type payload_t = logic,
  parameter int  MAX_DEPTH = 16
) (
  input  logic                 fastclock,
  input  logic                 rst_n,
  input  logic [SLIP_BITS-1:0] delay,
  input  payload_t             din,
  output payload_t             dout
);

  // shift chain, taps[0] is one cycle behind din
  payload_t taps [MAX_DEPTH];

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      for (int i = 0; i < MAX_DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= din;
      for (int i = 1; i < MAX_DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // tap select, total latency is delay plus one
  assign dout = taps[delay];

  // chain is flushed by reset so the selected tap stays known
  a_dout_known: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    !$isunknown(dout)
  );

endmodule

//--- verilog/bx_sequencer.sv
`timescale 1ns/1ps

module bx_sequencer import frame_pkg::*; #(
  parameter int WORD_SIZE = 8
) (
  input  logic fastclock,
  input  logic rst_n,
  output logic bx_strobe,
  output logic check_strobe
);

  localparam int FRAME_CYCLES = WORD_SIZE / 2;
  localparam int PHASE_BITS   = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
  localparam int FRAME_BITS   = (CHECK_FRAMES > 1) ? $clog2(CHECK_FRAMES) : 1;

  logic [PHASE_BITS-1:0] phase;
  logic [FRAME_BITS-1:0] frame_cnt;
  logic                  phase_end;
  logic                  frame_end;

  // last fastclock cycle of a frame and last frame of a check period
  assign phase_end = (phase == PHASE_BITS'(FRAME_CYCLES - 1));
  assign frame_end = (frame_cnt == FRAME_BITS'(CHECK_FRAMES - 1));

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      phase        <= '0;
      frame_cnt    <= '0;
      bx_strobe    <= 1'b0;
      check_strobe <= 1'b0;
    end else begin
      // registered strobes give the first bx pulse FRAME_CYCLES cycles after release
      bx_strobe    <= phase_end;
      check_strobe <= phase_end && frame_end;
      if (phase_end) begin
        phase     <= '0;
        frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // a check pulse is a bx pulse that follows another one a frame earlier
  a_check_on_bx: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    check_strobe |-> bx_strobe && $past(bx_strobe, FRAME_CYCLES)
  );

endmodule

//--- verilog/frame_aligner.sv
`timescale 1ns/1ps

module frame_aligner import frame_pkg::*; #(
  parameter int WORD_SIZE = 8
) (
  input  logic            fastclock,
  input  logic            rst_n,
  input  logic [MXIO-1:0] d0,
  input  logic [MXIO-1:0] d1,
  input  logic            sof,
  input  logic            mask,
  input  logic            bx_strobe,
  input  logic            check_strobe,
  sbit_link_if.source     link
);

  localparam int FRAME_CYCLES = WORD_SIZE / 2;
  localparam int STABLE_BITS  = $clog2(MXSTABLE);

  lane_pair_t                pair_in;
  lane_pair_t                pair_dly;
  logic                      sof_in;
  logic                      sof_line;
  logic [SLIP_BITS-1:0]      slip;
  logic [FRAME_CYCLES+1:0]   sof_pipe;
  logic                      sof_dly;
  logic                      sof_last;
  logic                      sof_last_last;
  logic                      sof_edge;
  logic [WORD_SIZE-1:0]      lane_word [MXIO];
  logic [MXIO*WORD_SIZE-1:0] word_flat;
  logic [STABLE_BITS-1:0]    stable_cnt;
  logic                      ready;
  logic                      alignment_error;
  logic [MXIO*WORD_SIZE-1:0] sbits_reg;

  // --------------------
  // input registers
  // --------------------

  always_ff @(posedge fastclock) begin
    pair_in.d0 <= d0;
    pair_in.d1 <= d1;
  end

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      sof_in <= 1'b0;
    end else begin
      sof_in <= sof;
    end
  end

  // --------------------
  // slip delay
  // --------------------

  // data and sof see the same programmable delay
  delay_line #(
    .payload_t (lane_pair_t),
    .MAX_DEPTH (2**SLIP_BITS)
  ) u_data_dly (
    .fastclock (fastclock),
    .rst_n     (rst_n),
    .delay     (slip),
    .din       (pair_in),
    .dout      (pair_dly)
  );

  delay_line #(
    .payload_t (logic),
    .MAX_DEPTH (2**SLIP_BITS)
  ) u_sof_dly (
    .fastclock (fastclock),
    .rst_n     (rst_n),
    .delay     (slip),
    .din       (sof_in),
    .dout      (sof_line)
  );

  // --------------------
  // deserializer
  // --------------------

  // d0 then d1 shifted in so the first bit of the frame ends up in the msb
  for (genvar i = 0; i < MXIO; i++) begin : g_lane
    always_ff @(posedge fastclock) begin
      lane_word[i] <= (lane_word[i] << 2) | WORD_SIZE'({pair_dly.d0[i], pair_dly.d1[i]});
    end
    assign word_flat[i*WORD_SIZE +: WORD_SIZE] = lane_word[i];
  end

  // tap FRAME_CYCLES-1 of the sof pipe matches a completed word
  // the two extra stages keep sof history for edge detection
  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      sof_pipe <= '0;
    end else begin
      sof_pipe <= {sof_pipe[FRAME_CYCLES:0], sof_line};
    end
  end

  assign sof_dly       = sof_pipe[FRAME_CYCLES-1];
  assign sof_last      = sof_pipe[FRAME_CYCLES];
  assign sof_last_last = sof_pipe[FRAME_CYCLES+1];

  // clean rising edge needs two low cycles first so a swapped pair cannot lock
  assign sof_edge = sof_dly && !sof_last && !sof_last_last;

  // --------------------
  // slip and lock control
  // --------------------

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      slip            <= '0;
      stable_cnt      <= '0;
      ready           <= 1'b0;
      alignment_error <= 1'b0;
    end else begin
      // try the next delay (wraps at 16) when a check frame has no edge
      if (check_strobe && !sof_edge) begin
        slip <= slip + 1'b1;
      end
      if (bx_strobe) begin
        alignment_error <= ready && !sof_edge;
        if (!sof_edge) begin
          stable_cnt <= '0;
          ready      <= 1'b0;
        end else if (stable_cnt == STABLE_BITS'(MXSTABLE - 1)) begin
          ready <= 1'b1;
        end else begin
          stable_cnt <= stable_cnt + 1'b1;
        end
      end
    end
  end

  // word latched once per frame and zero until locked or while masked
  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      sbits_reg <= '0;
    end else if (bx_strobe) begin
      sbits_reg <= (mask || !ready) ? '0 : word_flat;
    end
  end

  assign link.sbits           = sbits_reg;
  assign link.sof_delayed     = sof_dly;
  assign link.ready           = ready;
  assign link.alignment_error = alignment_error;

  // lock only follows a run of good frames so slip has settled
  a_slip_held_when_ready: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    ready |-> $stable(slip)
  );

  // an error is only raised by a channel that was locked after a full stable run
  a_error_needs_lock: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    $rose(alignment_error) |->
      $past(ready) && ($past(stable_cnt) == STABLE_BITS'(MXSTABLE - 1))
  );

endmodule

//--- verilog/sbit_collector.sv
`timescale 1ns/1ps

module sbit_collector import frame_pkg::*; #(
  parameter int NUM_CHANNELS = 3,
  parameter int WORD_SIZE    = 8
) (
  input  logic                                   fastclock,
  input  logic                                   rst_n,
  input  logic                                   bx_strobe,
  sbit_link_if.sink                              links [NUM_CHANNELS],
  output logic [NUM_CHANNELS*MXIO*WORD_SIZE-1:0] sbits,
  output logic                                   frame_valid,
  output logic [NUM_CHANNELS-1:0]                hit,
  output logic [NUM_CHANNELS-1:0]                ready,
  output logic [NUM_CHANNELS-1:0]                alignment_error,
  output logic [NUM_CHANNELS*ERR_COUNT_BITS-1:0] error_count
);

  localparam int CH_BITS = MXIO * WORD_SIZE;

  logic bx_d1;

  // aligner words settle one cycle after bx_strobe
  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      bx_d1       <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      bx_d1       <= bx_strobe;
      frame_valid <= bx_d1;
    end
  end

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_ch
    logic [CH_BITS-1:0]        sbits_q;
    logic                      hit_q;
    logic                      ready_q;
    logic                      err_q;
    logic [ERR_COUNT_BITS-1:0] err_cnt;

    always_ff @(posedge fastclock) begin
      if (!rst_n) begin
        sbits_q <= '0;
        hit_q   <= 1'b0;
        ready_q <= 1'b0;
        err_q   <= 1'b0;
        err_cnt <= '0;
      end else if (bx_d1) begin
        sbits_q <= links[ch].sbits;
        hit_q   <= |links[ch].sbits;
        ready_q <= links[ch].ready;
        err_q   <= links[ch].alignment_error;
        // one count per bad frame, saturating
        if (links[ch].alignment_error && (err_cnt != '1)) begin
          err_cnt <= err_cnt + 1'b1;
        end
      end
    end

    assign sbits[ch*CH_BITS +: CH_BITS]                      = sbits_q;
    assign hit[ch]                                           = hit_q;
    assign ready[ch]                                         = ready_q;
    assign alignment_error[ch]                               = err_q;
    assign error_count[ch*ERR_COUNT_BITS +: ERR_COUNT_BITS]  = err_cnt;

    // locked channel losing sof on a frame strobe must flag an error next cycle
    a_lost_sof_flags_error: assert property (
      @(posedge fastclock) disable iff (!rst_n)
      (bx_strobe && links[ch].ready && !links[ch].sof_delayed)
        |=> links[ch].alignment_error
    );
  end

endmodule

//--- verilog/trigger_rx.sv
`timescale 1ns/1ps

module trigger_rx import frame_pkg::*; #(
  parameter int NUM_CHANNELS = 3,
  parameter int WORD_SIZE    = 8
) (
  input  logic                                   fastclock,
  input  logic                                   rst_n,
  input  logic [NUM_CHANNELS*MXIO-1:0]           d0,
  input  logic [NUM_CHANNELS*MXIO-1:0]           d1,
  input  logic [NUM_CHANNELS-1:0]                sof,
  input  logic [NUM_CHANNELS-1:0]                mask,
  output logic [NUM_CHANNELS*MXIO*WORD_SIZE-1:0] sbits,
  output logic                                   frame_valid,
  output logic [NUM_CHANNELS-1:0]                hit,
  output logic [NUM_CHANNELS-1:0]                ready,
  output logic [NUM_CHANNELS-1:0]                alignment_error,
  output logic [NUM_CHANNELS*ERR_COUNT_BITS-1:0] error_count
);

  logic bx_strobe;
  logic check_strobe;

  sbit_link_if #(.WORD_SIZE(WORD_SIZE)) link [NUM_CHANNELS] ();

  // shared frame timing
  bx_sequencer #(.WORD_SIZE(WORD_SIZE)) u_seq (
    .fastclock    (fastclock),
    .rst_n        (rst_n),
    .bx_strobe    (bx_strobe),
    .check_strobe (check_strobe)
  );

  // one aligner per front-end chip
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_align
    frame_aligner #(.WORD_SIZE(WORD_SIZE)) u_aligner (
      .fastclock    (fastclock),
      .rst_n        (rst_n),
      .d0           (d0[ch*MXIO +: MXIO]),
      .d1           (d1[ch*MXIO +: MXIO]),
      .sof          (sof[ch]),
      .mask         (mask[ch]),
      .bx_strobe    (bx_strobe),
      .check_strobe (check_strobe),
      .link         (link[ch])
    );
  end

  sbit_collector #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .WORD_SIZE    (WORD_SIZE)
  ) u_collector (
    .fastclock       (fastclock),
    .rst_n           (rst_n),
    .bx_strobe       (bx_strobe),
    .links           (link),
    .sbits           (sbits),
    .frame_valid     (frame_valid),
    .hit             (hit),
    .ready           (ready),
    .alignment_error (alignment_error),
    .error_count     (error_count)
  );

endmodule

//--- testbench/tb_trigger_rx.sv
`timescale 1ns/1ps

module tb_trigger_rx import frame_pkg::*; ();

  localparam int NUM_CHANNELS = 3;
  localparam int WORD_SIZE    = 8;
  localparam int FRAME_CYCLES = WORD_SIZE / 2;
  localparam int CH_BITS      = MXIO * WORD_SIZE;
  localparam int MAX_FRAMES   = 16384;
  localparam int LOCK_LIMIT   = 16 * CHECK_FRAMES * FRAME_CYCLES + MXSTABLE * FRAME_CYCLES + 64;
  localparam int FRAME_LIMIT  = 2 * FRAME_CYCLES + 4;
  // old stream can still sit in the slip delay and the sof pipe
  localparam int ERROR_LIMIT  = 2**SLIP_BITS + 8 * FRAME_CYCLES + 8;
  // enough lost locks to drive the counter into saturation
  localparam int FAULTS       = 260;
  localparam logic [ERR_COUNT_BITS-1:0] ERR_MAX = '1;

  logic                                   fastclock;
  logic                                   rst_n;
  logic [NUM_CHANNELS*MXIO-1:0]           d0;
  logic [NUM_CHANNELS*MXIO-1:0]           d1;
  logic [NUM_CHANNELS-1:0]                sof;
  logic [NUM_CHANNELS-1:0]                mask;
  logic [NUM_CHANNELS*CH_BITS-1:0]        sbits;
  logic                                   frame_valid;
  logic [NUM_CHANNELS-1:0]                hit;
  logic [NUM_CHANNELS-1:0]                ready;
  logic [NUM_CHANNELS-1:0]                alignment_error;
  logic [NUM_CHANNELS*ERR_COUNT_BITS-1:0] error_count;

  // transmitter model with sent words per channel and link latency in cycles
  logic [CH_BITS-1:0] sent [NUM_CHANNELS][MAX_FRAMES];
  int                 lat [NUM_CHANNELS];
  // index of the sent word expected at the last frame_valid
  int                 idx [NUM_CHANNELS];
  logic [31:0]        rng;
  int                 cyc;
  int                 errors;
  int                 tests_failed;
  bit                 timed_out;
  string              test_name;

  trigger_rx #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .WORD_SIZE    (WORD_SIZE)
  ) u_dut (
    .fastclock       (fastclock),
    .rst_n           (rst_n),
    .d0              (d0),
    .d1              (d1),
    .sof             (sof),
    .mask            (mask),
    .sbits           (sbits),
    .frame_valid     (frame_valid),
    .hit             (hit),
    .ready           (ready),
    .alignment_error (alignment_error),
    .error_count     (error_count)
  );

  // 8 ns period
  always #4 fastclock = ~fastclock;

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // serializer sends the msb of each lane word first with d0 before d1 and sof on the first pair
  task automatic drive_links();
    int                 t;
    int                 k;
    int                 p;
    logic [CH_BITS-1:0] w;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      t = cyc - lat[ch];
      k = (t < 0) ? 0 : (t / FRAME_CYCLES) % MAX_FRAMES;
      p = (t < 0) ? 0 : t % FRAME_CYCLES;
      w = (t < 0) ? '0 : sent[ch][k];
      sof[ch] = (t >= 0) && (p == 0);
      for (int i = 0; i < MXIO; i++) begin
        d0[ch*MXIO + i] = w[i*WORD_SIZE + WORD_SIZE - 1 - 2*p];
        d1[ch*MXIO + i] = w[i*WORD_SIZE + WORD_SIZE - 2 - 2*p];
      end
    end
  endtask

  // one clock with inputs driven and outputs sampled 1 ns after the edge
  task automatic step();
    @(posedge fastclock);
    #1;
    cyc++;
    drive_links();
  endtask

  task automatic wait_frame();
    int n;
    n = 0;
    if (!timed_out) begin
      step();
      while (!frame_valid && n < FRAME_LIMIT) begin
        step();
        n++;
      end
      if (!frame_valid) begin
        $display("timeout: no frame_valid pulse within %0d cycles", FRAME_LIMIT);
        timed_out = 1'b1;
      end else begin
        // callers wait on back-to-back frames so pulses are due every FRAME_CYCLES cycles
        assert (n + 1 == FRAME_CYCLES) else begin
          $display("FAIL %s frame_valid spacing expected %0d actual %0d", test_name,
                   FRAME_CYCLES, n + 1);
          errors++;
        end
      end
    end
  endtask

  task automatic wait_ready(input logic [NUM_CHANNELS-1:0] sel, input int limit);
    int n;
    n = 0;
    while (!timed_out && (ready & sel) != sel && n < limit) begin
      step();
      n++;
    end
    if ((ready & sel) != sel) begin
      $display("timeout: ready %b did not cover %b within %0d cycles", ready, sel, limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_error(input int ch);
    int n;
    n = 0;
    while (!timed_out && !alignment_error[ch] && n < ERROR_LIMIT) begin
      step();
      n++;
    end
    if (!alignment_error[ch]) begin
      $display("timeout: channel %0d raised no alignment_error after a latency shift", ch);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_value(input string what, input logic [CH_BITS-1:0] exp,
                             input logic [CH_BITS-1:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic expect_idle();
    check_value("ready", '0, CH_BITS'(ready));
    check_value("alignment_error", '0, CH_BITS'(alignment_error));
    check_value("hit", '0, CH_BITS'(hit));
    check_value("error_count", '0, CH_BITS'(error_count));
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      check_value($sformatf("ch%0d sbits", ch), '0, sbits[ch*CH_BITS +: CH_BITS]);
    end
  endtask

  // next word of the stream or zero when masked
  task automatic verify_channel(input int ch);
    logic [CH_BITS-1:0] exp;
    idx[ch]++;
    exp = mask[ch] ? '0 : sent[ch][idx[ch] % MAX_FRAMES];
    check_value($sformatf("ch%0d sbits", ch), exp, sbits[ch*CH_BITS +: CH_BITS]);
    check_value($sformatf("ch%0d hit", ch), CH_BITS'(exp != '0), CH_BITS'(hit[ch]));
    check_value($sformatf("ch%0d ready", ch), CH_BITS'(1), CH_BITS'(ready[ch]));
    check_value($sformatf("ch%0d alignment_error", ch), '0, CH_BITS'(alignment_error[ch]));
  endtask

  task automatic report_test(input int errs0);
    if (timed_out) begin
      $display("%s: aborted", test_name);
      tests_failed++;
    end else if (errors == errs0) begin
      $display("%s: passed", test_name);
    end else begin
      $display("%s: failed with %0d errors", test_name, errors - errs0);
      tests_failed++;
    end
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    int          errs0;
    int          mc;
    int          rc;
    int          base;
    int          prev_cnt;
    int          k;
    bit          found;
    bit          synced [NUM_CHANNELS];

    fastclock    = 1'b0;
    rst_n        = 1'b0;
    d0           = '0;
    d1           = '0;
    sof          = '0;
    mask         = '0;
    rng          = 32'h17b7;
    cyc          = 0;
    errors       = 0;
    tests_failed = 0;
    timed_out    = 1'b0;

    // random frame words with about one in eight empty
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      lat[ch] = int'((next_rand() >> 16) % 12);
      idx[ch] = 0;
      for (int f = 0; f < MAX_FRAMES; f++) begin
        r  = next_rand();
        hi = next_rand();
        lo = next_rand();
        sent[ch][f] = (r[31:29] == 3'd0) ? '0 : CH_BITS'({hi, lo});
      end
    end
    drive_links();

    // reset held for 8 cycles with outputs idle before and after release
    test_name = "reset_state";
    errs0 = errors;
    for (int c = 1; c <= 16; c++) begin
      step();
      if (c == 8) begin
        rst_n = 1'b1;
      end
      if (c >= 2) begin
        expect_idle();
      end
    end
    report_test(errs0);

    test_name = "lock";
    errs0 = errors;
    wait_ready({NUM_CHANNELS{1'b1}}, LOCK_LIMIT);
    for (int f = 0; f < 8 && !timed_out; f++) begin
      wait_frame();
      check_value("ready", CH_BITS'({NUM_CHANNELS{1'b1}}), CH_BITS'(ready));
      check_value("alignment_error", '0, CH_BITS'(alignment_error));
    end
    report_test(errs0);

    // locate each channel's first nonzero output in its sent stream
    test_name = "word_stream";
    errs0 = errors;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      synced[ch] = 1'b0;
    end
    for (int f = 0; f < 16 && !timed_out; f++) begin
      wait_frame();
      for (int ch = 0; ch < NUM_CHANNELS && !timed_out; ch++) begin
        if (synced[ch]) begin
          verify_channel(ch);
        end else if (sbits[ch*CH_BITS +: CH_BITS] != '0) begin
          found = 1'b0;
          for (k = cyc / FRAME_CYCLES; k >= 0 && !found; k--) begin
            if (sent[ch][k] == sbits[ch*CH_BITS +: CH_BITS]) begin
              found   = 1'b1;
              idx[ch] = k;
            end
          end
          synced[ch] = 1'b1;
          assert (found) else begin
            $display("word_stream: channel %0d output word is not in its sent stream", ch);
            errors++;
          end
        end
      end
    end
    for (int ch = 0; ch < NUM_CHANNELS && !timed_out; ch++) begin
      assert (synced[ch]) else begin
        $display("word_stream: channel %0d never produced a nonzero word", ch);
        errors++;
      end
    end
    for (int f = 0; f < 64 && !timed_out; f++) begin
      wait_frame();
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        verify_channel(ch);
      end
    end
    report_test(errs0);

    // mask changes right after a frame_valid show up on the next one
    test_name = "mask";
    errs0 = errors;
    mc = int'((next_rand() >> 16) % NUM_CHANNELS);
    mask[mc] = 1'b1;
    for (int f = 0; f < 32 && !timed_out; f++) begin
      wait_frame();
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        verify_channel(ch);
      end
    end
    mask[mc] = 1'b0;
    for (int f = 0; f < 16 && !timed_out; f++) begin
      wait_frame();
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        verify_channel(ch);
      end
    end
    report_test(errs0);

    // latency toggles by one cycle and each shift costs one error and a relock
    test_name = "relock";
    errs0 = errors;
    rc = int'((next_rand() >> 16) % NUM_CHANNELS);
    base = lat[rc];
    for (int n = 0; n < FAULTS && !timed_out; n++) begin
      prev_cnt = int'(error_count[rc*ERR_COUNT_BITS +: ERR_COUNT_BITS]);
      lat[rc] = base + ((n % 2 == 0) ? 1 : 0);
      wait_error(rc);
      if (n == 0 && !timed_out) begin
        assert (int'(error_count[rc*ERR_COUNT_BITS +: ERR_COUNT_BITS]) > prev_cnt) else begin
          $display("FAIL %s ch%0d error_count expected above %0d actual %0d", test_name, rc,
                   prev_cnt, error_count[rc*ERR_COUNT_BITS +: ERR_COUNT_BITS]);
          errors++;
        end
      end
      wait_ready(NUM_CHANNELS'(1) << rc, LOCK_LIMIT);
    end
    if (!timed_out) begin
      check_value($sformatf("ch%0d error_count", rc), CH_BITS'(ERR_MAX),
                  CH_BITS'(error_count[rc*ERR_COUNT_BITS +: ERR_COUNT_BITS]));
    end
    report_test(errs0);

    $display("tests run 5, failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- trigger_rx.f
verilog/frame_pkg.sv
verilog/sbit_link_if.sv
verilog/delay_line.sv
verilog/bx_sequencer.sv
verilog/frame_aligner.sv
verilog/sbit_collector.sv
verilog/trigger_rx.sv
testbench/tb_trigger_rx.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_trigger_rx
FILELIST  := trigger_rx.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
